/* source/spiPkg.sv */
/*
 * SPI node shared definitions
 * Widths, pad structs, frame commands and FSM encodings
 */
`default_nettype none

package spiPkg;

	// --------------------
	// Data widths
	// --------------------
	typedef logic [7:0]  spiByte_t;
	typedef logic [31:0] csrWord_t;
	// CSR index, low bits of the frame address
	typedef logic [3:0]  csrAddr_t;
	typedef logic [31:0] frameAddr_t;
	typedef logic [15:0] frameLen_t;

	// Strap capture window after reset, in system cycles
	localparam int captureCycles = 16;

	// --------------------
	// Frame commands
	// --------------------
	// Other command values are ignored
	typedef enum logic [7:0]
	{
		cmdCsrRead  = 8'd0,
		cmdCsrWrite = 8'd1
	} spiCmd_t;

	// Slave frame phases
	typedef enum logic [2:0]
	{
		stAddr,
		stCmd,
		stLen,
		stDummy,
		stData
	} slaveState_t;

	// Master byte phases
	typedef enum logic [1:0]
	{
		mIdle,
		mShift,
		mDone
	} masterState_t;

	// --------------------
	// Pads
	// --------------------
	// Levels seen on the pads
	typedef struct packed
	{
		logic sck;
		logic mosi;
		logic miso;
		logic cs1N;
		logic cs2N;
	} spiPadIn_t;

	// Driven values plus output enables
	typedef struct packed
	{
		logic sck;
		logic mosi;
		logic miso;
		logic cs1N;
		logic cs2N;
		logic sckOe;
		logic mosiOe;
		logic misoOe;
		logic csOe;
	} spiPadOut_t;

	// CSR write request from the frame parser
	typedef struct packed
	{
		logic     en;
		csrAddr_t addr;
		csrWord_t data;
	} csrWrite_t;

endpackage

`default_nettype wire

/* source/spiClockDiv.sv */
/*
 * Clock-enable divider
 * One-cycle tick every clkDivHalf cycles while run is high
 */
`timescale 1ns/1ps
`default_nettype none

module spiClockDiv
#(
	// System cycles per SCK half period
	parameter int clkDivHalf = 4
)
(
	input  wire logic iSysClk,
	input  wire logic rstN,
	// High while the master shifts a byte
	input  wire logic run,
	output logic      tick
);

	// Down counter width, at least one bit
	localparam int cntW = (clkDivHalf > 2) ? $clog2(clkDivHalf) : 1;
	localparam logic [cntW-1:0] reloadVal = cntW'(clkDivHalf - 1);

	logic [cntW-1:0] cnt;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt  <= reloadVal;
			tick <= 1'b0;
		end
		else if (!run)
		begin
			// Idle, hold at reload so the first half period is full
			cnt  <= reloadVal;
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt  <= reloadVal;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/spiMasterByte.sv */
/*
 * SPI master byte engine, mode 0
 * SCK from divider ticks, MOSI held after falling SCK,
 * MISO captured on rising SCK, one-cycle done pulse
 */
`timescale 1ns/1ps
`default_nettype none

module spiMasterByte
#(
	// System cycles from SCK fall to MOSI update
	parameter int holdCycles = 2
)
(
	input  wire logic             iSysClk,
	input  wire logic             rstN,
	input  wire logic             tick,
	// Master role and capture done
	input  wire logic             enable,
	input  wire spiPkg::spiByte_t wrData,
	input  wire logic             wrValid,
	output logic                  wrReady,
	output spiPkg::spiByte_t      rdData,
	output logic                  rdValid,
	output logic                  busy,
	output logic                  sck,
	output logic                  mosi,
	input  wire logic             miso
);

	localparam int holdW = (holdCycles > 2) ? $clog2(holdCycles) : 1;
	localparam logic [holdW-1:0] holdLast = holdW'(holdCycles - 1);

	spiPkg::masterState_t state;
	spiPkg::spiByte_t     txShift;
	spiPkg::spiByte_t     rxShift;
	logic [2:0]           fallCnt;
	logic                 holdActive;
	logic [holdW-1:0]     holdCnt;
	logic                 accept;
	logic                 riseTick;
	logic                 fallTick;
	logic                 lastFall;
	logic                 holdDone;

	// --------------------
	// Handshake and edges
	// --------------------
	assign wrReady  = enable && (state == spiPkg::mIdle);
	assign accept   = wrReady && wrValid;
	assign busy     = (state != spiPkg::mIdle);
	// SCK low means this tick makes a rising edge
	assign riseTick = (state == spiPkg::mShift) && tick && !sck;
	assign fallTick = (state == spiPkg::mShift) && tick && sck;
	assign lastFall = fallTick && (fallCnt == 3'd7);
	assign holdDone = holdActive && (holdCnt == holdLast);
	// MSB first
	assign mosi     = txShift[7];

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state      <= spiPkg::mIdle;
			sck        <= 1'b0;
			fallCnt    <= 3'd0;
			holdActive <= 1'b0;
			holdCnt    <= '0;
			rdValid    <= 1'b0;
			txShift    <= '0;
		end
		else
		begin
			rdValid <= 1'b0;

			// Hold timer after each falling edge
			if (holdDone)
				holdActive <= 1'b0;
			else if (holdActive)
				holdCnt <= holdCnt + 1'b1;

			// MOSI load on accept, shift once hold expires
			if (accept)
				txShift <= wrData;
			else if (holdDone)
				txShift <= {txShift[6:0], 1'b0};

			case (state)
				spiPkg::mIdle:
				begin
					sck <= 1'b0;
					if (accept)
					begin
						fallCnt    <= 3'd0;
						holdActive <= 1'b0;
						state      <= spiPkg::mShift;
					end
				end
				spiPkg::mShift:
				begin
					if (tick)
						sck <= ~sck;
					if (lastFall)
					begin
						// Eighth fall, byte complete
						state   <= spiPkg::mDone;
						rdValid <= 1'b1;
					end
					else if (fallTick)
					begin
						fallCnt    <= fallCnt + 1'b1;
						holdActive <= 1'b1;
						holdCnt    <= '0;
					end
				end
				default:
				begin
					// Ready rises the cycle after the pulse
					state <= spiPkg::mIdle;
				end
			endcase
		end
	end

	// --------------------
	// Receive path
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (riseTick)
			rxShift <= {rxShift[6:0], miso};
		if (lastFall)
			rdData <= rxShift;
	end

endmodule

`default_nettype wire

/* source/spiSlaveFrame.sv */
/*
 * SPI slave frame parser, mode 0
 * Address, command, length and dummy header, then 4 CSR data bytes
 * Read data shifts out on MISO, MSB first
 */
`timescale 1ns/1ps
`default_nettype none

module spiSlaveFrame
(
	input  wire logic              iSysClk,
	input  wire logic              rstN,
	// Slave role and capture done
	input  wire logic              enable,
	input  wire spiPkg::spiPadIn_t pad,
	output logic                   miso,
	output spiPkg::csrWrite_t      csrWr,
	output spiPkg::csrAddr_t       csrRdAddr,
	input  wire spiPkg::csrWord_t  csrRdData
);

	logic [2:0]          sckSync;
	logic [2:0]          mosiSync;
	logic [2:0]          csSync;
	logic                sckRise;
	logic                sckFall;
	logic                frameIdle;
	logic                phaseEnd;
	logic                addrInRange;
	logic [4:0]          bitCnt;
	logic [4:0]          phaseLast;
	spiPkg::slaveState_t state;
	spiPkg::csrWord_t    rxShift;
	spiPkg::csrWord_t    rxNext;
	spiPkg::csrWord_t    misoShift;
	spiPkg::frameAddr_t  frameAddr;
	spiPkg::spiCmd_t     frameCmd;
	spiPkg::frameLen_t   frameLen;

	// --------------------
	// Pin synchronizers
	// --------------------
	// Bit 0 newest, bit 2 oldest
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSync  <= 3'b000;
			mosiSync <= 3'b000;
			csSync   <= 3'b111;
		end
		else
		begin
			sckSync  <= {sckSync[1:0], pad.sck};
			mosiSync <= {mosiSync[1:0], pad.mosi};
			csSync   <= {csSync[1:0], pad.cs1N};
		end
	end

	assign sckRise   = !sckSync[2] && sckSync[1];
	assign sckFall   = sckSync[2] && !sckSync[1];
	// Deselected or wrong role holds the parser at the start
	assign frameIdle = csSync[2] || !enable;
	// MOSI bit aligned with the detected rising edge
	assign rxNext    = {rxShift[30:0], mosiSync[1]};

	// Last bit index of each phase
	always_comb
	begin
		case (state)
			spiPkg::stCmd:   phaseLast = 5'd7;
			spiPkg::stLen:   phaseLast = 5'd15;
			spiPkg::stDummy: phaseLast = 5'd7;
			default:         phaseLast = 5'd31;
		endcase
	end

	assign phaseEnd    = !frameIdle && sckRise && (bitCnt == phaseLast);
	// Only the first 16 CSRs exist
	assign addrInRange = (frameAddr[31:4] == '0);
	assign csrRdAddr   = frameAddr[3:0];
	assign miso        = misoShift[31];

	// --------------------
	// Phase FSM
	// --------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= spiPkg::stAddr;
			bitCnt    <= 5'd0;
			csrWr     <= '0;
			misoShift <= '0;
		end
		else
		begin
			csrWr.en <= 1'b0;
			if (frameIdle)
			begin
				state  <= spiPkg::stAddr;
				bitCnt <= 5'd0;
			end
			else if (phaseEnd)
			begin
				bitCnt <= 5'd0;
				case (state)
					spiPkg::stAddr:  state <= spiPkg::stCmd;
					spiPkg::stCmd:   state <= spiPkg::stLen;
					spiPkg::stLen:   state <= spiPkg::stDummy;
					spiPkg::stDummy:
					begin
						state <= spiPkg::stData;
						// Read word ready before the first data fall
						if (frameCmd == spiPkg::cmdCsrRead && addrInRange)
							misoShift <= csrRdData;
						else
							misoShift <= '0;
					end
					default:
					begin
						state <= spiPkg::stAddr;
						// Write issued the cycle after the 32nd bit
						if (frameCmd == spiPkg::cmdCsrWrite && addrInRange)
						begin
							csrWr.en   <= 1'b1;
							csrWr.addr <= csrRdAddr;
							csrWr.data <= rxNext;
						end
					end
				endcase
			end
			else if (sckRise)
				bitCnt <= bitCnt + 1'b1;

			// Skip the fall before data bit 0, MSB is already out
			if (!frameIdle && sckFall && state == spiPkg::stData && bitCnt != 5'd0)
				misoShift <= {misoShift[30:0], 1'b0};
		end
	end

	// --------------------
	// Header capture
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (sckRise)
			rxShift <= rxNext;
		if (phaseEnd)
		begin
			case (state)
				spiPkg::stAddr: frameAddr <= rxNext;
				spiPkg::stCmd:  frameCmd  <= spiPkg::spiCmd_t'(rxNext[7:0]);
				// Length kept for the frame, CSR access is always 4 bytes
				spiPkg::stLen:  frameLen  <= rxNext[15:0];
				default:        frameLen  <= frameLen;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/spiCsrBank.sv */
/*
 * CSR bank
 * Sixteen 32-bit registers, written by the slave frame parser
 */
`timescale 1ns/1ps
`default_nettype none

module spiCsrBank
(
	input  wire logic              iSysClk,
	input  wire logic              rstN,
	input  wire spiPkg::csrWrite_t csrWr,
	input  wire spiPkg::csrAddr_t  rdAddr,
	output spiPkg::csrWord_t       rdData
);

	// One register per index value
	localparam int csrCount = 2 ** $bits(spiPkg::csrAddr_t);

	spiPkg::csrWord_t regs [csrCount];

	// --------------------
	// Write port
	// --------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			// All registers read zero after reset
			for (int i = 0; i < csrCount; i++)
				regs[i] <= '0;
		end
		else if (csrWr.en)
		begin
			regs[csrWr.addr] <= csrWr.data;
		end
	end

	// --------------------
	// Read port
	// --------------------
	// Combinational, same cycle as the index
	assign rdData = regs[rdAddr];

endmodule

`default_nettype wire

/* source/spiRoleSelect.sv */
/*
 * Role select
 * Samples the cs2N strap after reset and freezes master or slave role
 */
`timescale 1ns/1ps
`default_nettype none

module spiRoleSelect
(
	input  wire logic iSysClk,
	input  wire logic rstN,
	// Strap pad, high selects master
	input  wire logic cs2N,
	output logic      isMaster,
	output logic      captureDone
);

	localparam int cntW = $clog2(spiPkg::captureCycles);
	localparam logic [cntW-1:0] cntLast = cntW'(spiPkg::captureCycles - 1);

	logic [1:0]      strapSync;
	logic [cntW-1:0] cnt;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			strapSync   <= 2'b11;
			cnt         <= '0;
			captureDone <= 1'b0;
			isMaster    <= 1'b0;
		end
		else if (!captureDone)
		begin
			strapSync <= {strapSync[0], cs2N};
			// Window end, role fixed until next reset
			if (cnt == cntLast)
			begin
				captureDone <= 1'b1;
				isMaster    <= strapSync[1];
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/spiNode.sv */
/*
 * SPI node top level
 * One pad set, master or slave by strap, CSR bank behind the slave
 */
`timescale 1ns/1ps
`default_nettype none

module spiNode
#(
	parameter int clkDivHalf = 4,
	parameter int holdCycles = 2
)
(
	input  wire logic              iSysClk,
	input  wire logic              rstN,
	input  wire spiPkg::spiPadIn_t padIn,
	output spiPkg::spiPadOut_t     padOut,
	// Host byte port
	input  wire spiPkg::spiByte_t  hostWrData,
	input  wire logic              hostWrValid,
	output logic                   hostWrReady,
	output spiPkg::spiByte_t       hostRdData,
	output logic                   hostRdValid,
	input  wire logic              hostCs1N,
	input  wire logic              hostCs2N,
	output logic                   isMaster
);

	logic              captureDone;
	logic              masterEn;
	logic              slaveEn;
	logic              divTick;
	logic              masterBusy;
	logic              masterSck;
	logic              masterMosi;
	logic              slaveMiso;
	spiPkg::csrWrite_t csrWr;
	spiPkg::csrAddr_t  csrRdAddr;
	spiPkg::csrWord_t  csrRdData;

	// Nothing driven before the role is known
	assign masterEn = captureDone && isMaster;
	assign slaveEn  = captureDone && !isMaster;

	spiRoleSelect u_roleSelect (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.cs2N        (padIn.cs2N),
		.isMaster    (isMaster),
		.captureDone (captureDone)
	);

	spiClockDiv #(
		.clkDivHalf (clkDivHalf)
	) u_clockDiv (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.run     (masterBusy),
		.tick    (divTick)
	);

	spiMasterByte #(
		.holdCycles (holdCycles)
	) u_master (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.tick    (divTick),
		.enable  (masterEn),
		.wrData  (hostWrData),
		.wrValid (hostWrValid),
		.wrReady (hostWrReady),
		.rdData  (hostRdData),
		.rdValid (hostRdValid),
		.busy    (masterBusy),
		.sck     (masterSck),
		.mosi    (masterMosi),
		.miso    (padIn.miso)
	);

	spiSlaveFrame u_slave (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.enable    (slaveEn),
		.pad       (padIn),
		.miso      (slaveMiso),
		.csrWr     (csrWr),
		.csrRdAddr (csrRdAddr),
		.csrRdData (csrRdData)
	);

	spiCsrBank u_csrBank (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.csrWr   (csrWr),
		.rdAddr  (csrRdAddr),
		.rdData  (csrRdData)
	);

	// --------------------
	// Pad drive
	// --------------------
	assign padOut.sck    = masterSck;
	assign padOut.mosi   = masterMosi;
	assign padOut.miso   = slaveMiso;
	assign padOut.cs1N   = hostCs1N;
	assign padOut.cs2N   = hostCs2N;
	assign padOut.sckOe  = masterEn;
	assign padOut.mosiOe = masterEn;
	assign padOut.csOe   = masterEn;
	// Slave drives MISO only while selected
	assign padOut.misoOe = slaveEn && !padIn.cs1N;

endmodule

`default_nettype wire

/* sim/spiNodeAssertions.sv */
/*
 * SPI node bound checks
 * Capture window, pad enable gating and hostRdValid pulse width
 */
`timescale 1ns/1ps
`default_nettype none

module spiNodeAssertions
(
	input  wire logic               iSysClk,
	input  wire logic               rstN,
	input  wire spiPkg::spiPadIn_t  padIn,
	input  wire spiPkg::spiPadOut_t padOut,
	input  wire logic               captureDone,
	input  wire logic               isMaster,
	input  wire logic               hostRdValid
);

	localparam int cntW = $clog2(spiPkg::captureCycles + 1);
	localparam logic [cntW-1:0] windowEnd = cntW'(spiPkg::captureCycles);

	logic [cntW-1:0] sinceReset;
	// Sticky flags, one per check
	logic windowFail = 1'b0;
	logic idleFail   = 1'b0;
	logic sckFail    = 1'b0;
	logic misoFail   = 1'b0;
	logic pulseFail  = 1'b0;
	logic anyFail;

	assign anyFail = windowFail || idleFail || sckFail || misoFail || pulseFail;

	// Cycles since reset, saturates at the window end
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			sinceReset <= '0;
		else if (sinceReset != windowEnd)
			sinceReset <= sinceReset + 1'b1;
	end

	// --------------------
	// Role and enables
	// --------------------
	windowCheck: assert property (@(posedge iSysClk) disable iff (!rstN)
		captureDone == (sinceReset == windowEnd))
	else
	begin
		windowFail = 1'b1;
		$error("captureDone does not match the capture window");
	end

	// Nothing driven before the role is fixed
	idleCheck: assert property (@(posedge iSysClk) disable iff (!rstN)
		!captureDone |->
			!(padOut.sckOe || padOut.mosiOe || padOut.misoOe || padOut.csOe))
	else
	begin
		idleFail = 1'b1;
		$error("Pad enable high before captureDone");
	end

	sckCheck: assert property (@(posedge iSysClk) disable iff (!rstN)
		(captureDone && !isMaster) |-> !padOut.sckOe)
	else
	begin
		sckFail = 1'b1;
		$error("sckOe high in slave role");
	end

	// MISO only as a selected slave
	misoCheck: assert property (@(posedge iSysClk) disable iff (!rstN)
		padOut.misoOe |-> (captureDone && !isMaster && !padIn.cs1N))
	else
	begin
		misoFail = 1'b1;
		$error("misoOe high outside selected slave role");
	end

	// --------------------
	// Host pulse
	// --------------------
	pulseCheck: assert property (@(posedge iSysClk) disable iff (!rstN)
		hostRdValid |=> !hostRdValid)
	else
	begin
		pulseFail = 1'b1;
		$error("hostRdValid longer than one cycle");
	end

endmodule

`default_nettype wire

/* sim/spiNodeTb.sv */
/*
 * SPI node testbench
 * Master role bytes against a slave model, then slave role CSR frames
 * from a master model
 */
`timescale 1ns/1ps
`default_nettype none

module spiNodeTb;

	localparam int clkDivHalf = 4;
	localparam int holdCycles = 2;
	// Master model SCK half period, system cycles
	localparam int halfPeriod = 8;
	// Two resets, four bytes of ~80 cycles, about seven frames of ~1600 cycles
	localparam int cycleLimit = 20000;

	logic               iSysClk;
	logic               rstN;
	logic               tbSck;
	logic               tbMosi;
	logic               tbMiso = 1'b0;
	logic               tbCs1N;
	logic               tbCs2N;
	spiPkg::spiPadIn_t  padIn;
	spiPkg::spiPadOut_t padOut;
	spiPkg::spiByte_t   hostWrData;
	logic               hostWrValid;
	logic               hostWrReady;
	spiPkg::spiByte_t   hostRdData;
	logic               hostRdValid;
	logic               hostCs1N;
	logic               hostCs2N;
	logic               isMaster;
	integer             seed;
	int                 cycleCount = 0;
	// Slave model state
	logic               prevSck = 1'b0;
	spiPkg::spiByte_t   replyByte;
	spiPkg::spiByte_t   replyShift;
	spiPkg::spiByte_t   mosiSeen;

	// Pad order follows the struct, sck first
	assign padIn = {tbSck, tbMosi, tbMiso, tbCs1N, tbCs2N};

	spiNode #(
		.clkDivHalf (clkDivHalf),
		.holdCycles (holdCycles)
	) u_dut (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.padIn       (padIn),
		.padOut      (padOut),
		.hostWrData  (hostWrData),
		.hostWrValid (hostWrValid),
		.hostWrReady (hostWrReady),
		.hostRdData  (hostRdData),
		.hostRdValid (hostRdValid),
		.hostCs1N    (hostCs1N),
		.hostCs2N    (hostCs2N),
		.isMaster    (isMaster)
	);

	bind spiNode spiNodeAssertions u_assertions (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.padIn       (padIn),
		.padOut      (padOut),
		.captureDone (captureDone),
		.isMaster    (isMaster),
		.hostRdValid (hostRdValid)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #20 iSysClk = ~iSysClk;
	end

	// --------------------
	// Failure reporting
	// --------------------
	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
			stopWithFailure($sformatf("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual));
	endtask

	// Cycle limit and bound assertion watch
	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			stopWithFailure($sformatf("Timeout after %0d cycles", cycleCount));
		else if (u_dut.u_assertions.anyFail)
			stopWithFailure("A bound assertion on spiNode failed");
	end

	// --------------------
	// SPI slave model
	// --------------------
	// Pad values read here are the ones from before the edge
	always @(posedge iSysClk)
	begin
		prevSck <= padOut.sck;
		if (hostWrValid && hostWrReady)
		begin
			// Byte accepted, first reply bit out before the first rise
			replyShift <= replyByte;
			tbMiso     <= replyByte[7];
		end
		else if (prevSck && !padOut.sck)
		begin
			replyShift <= {replyShift[6:0], 1'b0};
			tbMiso     <= replyShift[6];
		end
		// MOSI bit taken on each rising SCK
		if (!prevSck && padOut.sck)
			mosiSeen <= {mosiSeen[6:0], padOut.mosi};
	end

	// Reset with the cs2N strap held, then wait out the capture window
	task automatic resetDut(input logic strap);
		@(posedge iSysClk);
		rstN        <= 1'b0;
		tbCs2N      <= strap;
		tbCs1N      <= 1'b1;
		tbSck       <= 1'b0;
		hostWrValid <= 1'b0;
		repeat (5) @(posedge iSysClk);
		rstN <= 1'b1;
		repeat (spiPkg::captureCycles + 4) @(posedge iSysClk);
	endtask

	// One host byte, MISO reply from the slave model
	task automatic sendHostByte(input spiPkg::spiByte_t txByte, input spiPkg::spiByte_t rxByte);
		while (!hostWrReady)
			@(posedge iSysClk);
		hostWrData  <= txByte;
		hostWrValid <= 1'b1;
		replyByte   <= rxByte;
		@(posedge iSysClk);
		hostWrValid <= 1'b0;
		@(posedge iSysClk);
		while (!hostRdValid)
			@(posedge iSysClk);
		checkValue("hostRdData", 32'(hostRdData), 32'(rxByte));
		checkValue("MOSI byte", 32'(mosiSeen), 32'(txByte));
	endtask

	// --------------------
	// SPI master model
	// --------------------
	// Header of address, command, length 4 and dummy, then the data word
	function automatic logic [95:0] buildFrame(input spiPkg::frameAddr_t addr,
		input spiPkg::spiByte_t cmd, input spiPkg::csrWord_t data);
		return {addr, cmd, 16'd4, 8'h00, data};
	endfunction

	// Shifts the first nBits of a frame, MISO kept from the data phase
	task automatic runFrame(input logic [95:0] bits, input int nBits,
		output spiPkg::csrWord_t misoWord);
		misoWord = '0;
		tbCs1N <= 1'b0;
		repeat (halfPeriod) @(posedge iSysClk);
		for (int i = 95; i > 95 - nBits; i--)
		begin
			tbMosi <= bits[i];
			tbSck  <= 1'b0;
			repeat (halfPeriod) @(posedge iSysClk);
			tbSck <= 1'b1;
			if (i < 32)
			begin
				misoWord[i] = padOut.miso;
				// Selected slave drives MISO
				checkValue("padOut.misoOe", 32'(padOut.misoOe), 32'd1);
			end
			repeat (halfPeriod) @(posedge iSysClk);
		end
		tbSck <= 1'b0;
		repeat (halfPeriod) @(posedge iSysClk);
		tbCs1N <= 1'b1;
		repeat (2 * halfPeriod) @(posedge iSysClk);
	endtask

	task automatic writeCsr(input spiPkg::frameAddr_t addr, input spiPkg::csrWord_t data);
		spiPkg::csrWord_t unused;
		runFrame(buildFrame(addr, spiPkg::cmdCsrWrite, data), 96, unused);
	endtask

	task automatic readCsr(input spiPkg::frameAddr_t addr, output spiPkg::csrWord_t data);
		runFrame(buildFrame(addr, spiPkg::cmdCsrRead, '0), 96, data);
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin
		spiPkg::spiByte_t txByte;
		spiPkg::spiByte_t rxByte;
		spiPkg::csrWord_t storedWord;
		spiPkg::csrWord_t readWord;

		seed        = 32'h7fb83820;
		rstN        = 1'b0;
		tbSck       = 1'b0;
		tbMosi      = 1'b0;
		tbCs1N      = 1'b1;
		tbCs2N      = 1'b1;
		hostWrData  = '0;
		hostWrValid = 1'b0;
		hostCs1N    = 1'b1;
		hostCs2N    = 1'b1;

		// Strap high, master role
		resetDut(1'b1);
		checkValue("isMaster", 32'(isMaster), 32'd1);
		checkValue("padOut.sckOe", 32'(padOut.sckOe), 32'd1);
		checkValue("padOut.mosiOe", 32'(padOut.mosiOe), 32'd1);
		checkValue("padOut.csOe", 32'(padOut.csOe), 32'd1);

		// Host chip selects go straight to the pads
		hostCs1N <= 1'b0;
		@(posedge iSysClk);
		checkValue("padOut.cs1N", 32'(padOut.cs1N), 32'd0);
		checkValue("padOut.cs2N", 32'(padOut.cs2N), 32'd1);
		repeat (4)
		begin
			txByte = 8'($random(seed));
			rxByte = 8'($random(seed));
			sendHostByte(txByte, rxByte);
		end
		hostCs1N <= 1'b1;
		hostCs2N <= 1'b0;
		@(posedge iSysClk);
		checkValue("padOut.cs1N", 32'(padOut.cs1N), 32'd1);
		checkValue("padOut.cs2N", 32'(padOut.cs2N), 32'd0);

		// Strap low, slave role
		resetDut(1'b0);
		checkValue("isMaster", 32'(isMaster), 32'd0);
		checkValue("padOut.sckOe", 32'(padOut.sckOe), 32'd0);
		checkValue("padOut.mosiOe", 32'(padOut.mosiOe), 32'd0);
		checkValue("padOut.csOe", 32'(padOut.csOe), 32'd0);

		// Write then read back CSR 5
		storedWord = $random(seed);
		writeCsr(32'd5, storedWord);
		readCsr(32'd5, readWord);
		checkValue("CSR 5 on padOut.miso", readWord, storedWord);

		// Never written CSR reads zero
		readCsr(32'd3, readWord);
		checkValue("CSR 3 on padOut.miso", readWord, 32'd0);

		// Address 16 is out of range, CSR 0 untouched
		writeCsr(32'h10, $random(seed));
		readCsr(32'd0, readWord);
		checkValue("CSR 0 on padOut.miso", readWord, 32'd0);

		// Abort mid-address, next frame starts clean
		runFrame(buildFrame(32'd5, spiPkg::cmdCsrRead, '0), 12, readWord);
		readCsr(32'd5, readWord);
		checkValue("CSR 5 after abort", readWord, storedWord);

		repeat (4) @(posedge iSysClk);
		if (u_dut.u_assertions.anyFail)
			stopWithFailure("A bound assertion on spiNode failed");
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
source/spiPkg.sv
source/spiClockDiv.sv
source/spiMasterByte.sv
source/spiSlaveFrame.sv
source/spiCsrBank.sv
source/spiRoleSelect.sv
source/spiNode.sv
sim/spiNodeAssertions.sv
sim/spiNodeTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SPI node regression with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simExe=spiNodeSim
logFile=sim.log

verilator --binary --assert --timing -f sources.f --top-module spiNodeTb \
	-Mdir "$buildDir" -o "$simExe"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Error limit raised so the testbench sees bound assertion failures itself
"./$buildDir/$simExe" +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Regression passed$" "$logFile"; then
	exit 0
fi
echo "Pass line not found in $logFile"
exit 1
